//--- Makefile
# Verilator build and run of the decode testbench

sim:
	verilator --binary --timing --top-module tb_id_top -f sources.f --Mdir obj_dir -o tb_id_top
	./obj_dir/tb_id_top | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- sources.f
+incdir+include
src/id_pkg.sv
src/id_fetch_latch.sv
src/id_ctrl_decoder.sv
src/id_imm_gen.sv
src/id_regfile.sv
src/id_issue_reg.sv
src/id_top.sv
test/tb_id_top.sv

//--- src/id_ctrl_decoder.sv
// instruction classifier: rv64i matching, format grouping, control bundle and immediate format
module id_ctrl_decoder import id_pkg::*; (
  input  logic [INST_W-1:0] i_inst,
  output ctrl_t             o_ctrl,
  output imm_fmt_e          o_imm_fmt
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       f7_zero;
  logic       f7_alt;
  logic       f7_pair;
  logic       sh_zero;
  logic       sh_alt;
  logic       imm_alt;
  logic       imm_ok;
  logic       imm32_ok;
  logic       reg_ok;
  logic       reg32_ok;

  logic       t_r, t_i, t_u, t_s, t_b, t_j;
  logic       pc_rel;  // alu a takes pc
  logic       link;    // jal / jalr
  logic       ld;
  logic       word;
  logic       matched;
  alu_op_e    alu;
  mem_op_e    mop;
  br_func_e   bfn;

  function automatic alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode  = opcode_e'(i_inst[6:0]);
  assign funct3  = i_inst[14:12];
  assign f7_zero = (i_inst[31:25] == 7'b0000000);
  assign f7_alt  = (i_inst[31:25] == 7'b0100000);
  assign f7_pair = f7_zero | f7_alt;
  assign sh_zero = (i_inst[31:26] == 6'b000000);  // 6-bit shamt on rv64
  assign sh_alt  = (i_inst[31:26] == 6'b010000);
  assign imm_alt = (funct3 == 3'b101) & i_inst[30];  // srai only, bit 30 is imm elsewhere

  // legal funct3/funct7 combinations per arithmetic opcode
  assign imm_ok   = (funct3 == 3'b001) ? sh_zero :
                    (funct3 == 3'b101) ? (sh_zero | sh_alt) : 1'b1;
  assign imm32_ok = (funct3 == 3'b000) | ((funct3 == 3'b001) & f7_zero) |
                    ((funct3 == 3'b101) & f7_pair);
  assign reg_ok   = (funct3 == 3'b000 || funct3 == 3'b101) ? f7_pair : f7_zero;
  assign reg32_ok = (funct3 == 3'b000 || funct3 == 3'b101) ? f7_pair :
                    ((funct3 == 3'b001) & f7_zero);

  always_comb begin
    {t_r, t_i, t_u, t_s, t_b, t_j} = '0;
    pc_rel = 1'b0;
    link   = 1'b0;
    ld     = 1'b0;
    word   = 1'b0;
    alu    = ALU_INVALID;
    mop    = MEM_NONE;
    bfn    = BR_JAL;
    case (opcode)
      OPC_LUI: begin
        t_u = 1'b1;
        alu = ALU_COPY_IMM;
      end
      OPC_AUIPC: begin
        t_u    = 1'b1;
        pc_rel = 1'b1;
        alu    = ALU_ADD;
      end
      OPC_JAL: begin
        t_j    = 1'b1;
        pc_rel = 1'b1;
        link   = 1'b1;
        alu    = ALU_ADD;
      end
      OPC_JALR: if (funct3 == 3'b000) begin
        t_i    = 1'b1;
        pc_rel = 1'b1;
        link   = 1'b1;
        alu    = ALU_ADD;
        bfn    = BR_JALR;
      end
      OPC_BRANCH: if (funct3[2:1] != 2'b01) begin
        t_b = 1'b1;
        alu = ALU_SUB;  // compare
        bfn = br_func_e'(funct3[2] ? funct3 : {2'b01, funct3[0]});
      end
      OPC_LOAD: if (funct3 != 3'b111) begin
        t_i = 1'b1;
        ld  = 1'b1;
        alu = ALU_ADD;
        mop = mem_op_e'({funct3[1:0], funct3[2]});  // size, then unsigned bit
      end
      OPC_STORE: if (!funct3[2]) begin
        t_s = 1'b1;
        alu = ALU_ADD;
        mop = mem_op_e'({funct3[1:0], 1'b0});
      end
      OPC_OP_IMM: if (imm_ok) begin
        t_i = 1'b1;
        alu = alu_of(funct3, imm_alt);
      end
      OPC_OP_IMM_32: if (imm32_ok) begin
        t_i  = 1'b1;
        word = 1'b1;
        alu  = alu_of(funct3, imm_alt);
      end
      OPC_OP: if (reg_ok) begin
        t_r = 1'b1;
        alu = alu_of(funct3, i_inst[30]);
      end
      OPC_OP_32: if (reg32_ok) begin
        t_r  = 1'b1;
        word = 1'b1;
        alu  = alu_of(funct3, i_inst[30]);
      end
      default: ;
    endcase
  end

  assign matched = |{t_r, t_i, t_u, t_s, t_b, t_j};

  assign o_ctrl.alu_op     = alu;
  assign o_ctrl.a_src_pc   = pc_rel;
  assign o_ctrl.b_src      = link ? B_CONST4 : ((t_i | t_u | t_s) ? B_IMM : B_RS2);
  assign o_ctrl.word_cut   = word;
  assign o_ctrl.reg_wr     = t_r | t_i | t_u | t_j;
  assign o_ctrl.mem_to_reg = ld;
  assign o_ctrl.mem_wr     = t_s;
  assign o_ctrl.mem_re     = ld;
  assign o_ctrl.mem_op     = mop;
  assign o_ctrl.br_en      = t_b | link;
  assign o_ctrl.br_func    = bfn;
  assign o_ctrl.invalid    = !matched && (i_inst != '0);  // zero word is a bubble

  assign o_imm_fmt = t_i ? IMM_I :
                     t_u ? IMM_U :
                     t_s ? IMM_S :
                     t_b ? IMM_B :
                     t_j ? IMM_J : IMM_NONE;

endmodule

//--- src/id_fetch_latch.sv
// input stage register with accepted instruction, its pc and valid flag
module id_fetch_latch import id_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  fetch_pkt_t i_fetch,
  input  logic       i_fetch_valid,
  input  logic       i_advance,
  output fetch_pkt_t o_held,
  output logic       o_held_valid
);

  // decoder sees an all-zero word out of reset
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_held_valid <= 1'b0;
      o_held       <= '0;
    end else if (i_advance) begin
      o_held_valid <= i_fetch_valid;
      o_held.pc    <= i_fetch.pc;
      o_held.inst  <= i_fetch_valid ? i_fetch.inst : '0;  // empty slot -> bubble
    end
  end

endmodule

//--- src/id_imm_gen.sv
// immediate generator: sign-extended i/u/s/b/j immediates selected by format
module id_imm_gen import id_pkg::*; (
  input  logic [INST_W-1:0] i_inst,
  input  imm_fmt_e          i_imm_fmt,
  output logic [XLEN-1:0]   o_imm
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};  // halfword offset
  assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    case (i_imm_fmt)
      IMM_I:   o_imm = imm_i;
      IMM_U:   o_imm = imm_u;
      IMM_S:   o_imm = imm_s;
      IMM_B:   o_imm = imm_b;
      IMM_J:   o_imm = imm_j;
      default: o_imm = '0;  // none and unused codes
    endcase
  end

endmodule

//--- src/id_issue_reg.sv
// output stage register: issue packet and valid flag toward execute
module id_issue_reg import id_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_advance,
  input  logic     i_valid,
  input  dec_pkt_t i_pkt,
  output dec_pkt_t o_dec,
  output logic     o_dec_valid
);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dec_valid <= 1'b0;
    end else if (i_advance) begin
      o_dec_valid <= i_valid;
    end
  end

  // held unchanged while execute stalls
  always_ff @(posedge i_clk) begin
    if (i_advance) begin
      o_dec <= i_pkt;
    end
  end

endmodule

//--- src/id_pkg.sv
// decode package: widths, opcode/alu/memory/branch/immediate encodings, packet structs
package id_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;

  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP        = 7'b0110011,
    OPC_OP_32     = 7'b0111011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD      = 5'd0,
    ALU_SUB      = 5'd1,
    ALU_SLT      = 5'd2,
    ALU_SLTU     = 5'd3,
    ALU_XOR      = 5'd4,
    ALU_AND      = 5'd5,
    ALU_OR       = 5'd6,
    ALU_SLL      = 5'd7,
    ALU_SRL      = 5'd8,
    ALU_SRA      = 5'd9,
    ALU_COPY_IMM = 5'd15,
    ALU_INVALID  = 5'd31
  } alu_op_e;

  // stores share the signed load codes
  typedef enum logic [2:0] {
    MEM_SB_LB = 3'd0,
    MEM_LBU   = 3'd1,
    MEM_SH_LH = 3'd2,
    MEM_LHU   = 3'd3,
    MEM_SW_LW = 3'd4,
    MEM_LWU   = 3'd5,
    MEM_SD_LD = 3'd6,
    MEM_NONE  = 3'd7
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_JAL  = 3'd0,
    BR_JALR = 3'd1,
    BR_BEQ  = 3'd2,
    BR_BNE  = 3'd3,
    BR_BLT  = 3'd4,
    BR_BGE  = 3'd5,
    BR_BLTU = 3'd6,
    BR_BGEU = 3'd7
  } br_func_e;

  typedef enum logic [1:0] {
    B_RS2    = 2'd0,
    B_IMM    = 2'd1,
    B_CONST4 = 2'd2  // link address pc + 4
  } alu_b_src_e;

  typedef enum logic [2:0] {
    IMM_I    = 3'd0,
    IMM_U    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_J    = 3'd4,
    IMM_NONE = 3'd5
  } imm_fmt_e;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       a_src_pc;
    alu_b_src_e b_src;
    logic       word_cut;
    logic       reg_wr;
    logic       mem_to_reg;
    logic       mem_wr;
    logic       mem_re;
    mem_op_e    mem_op;
    logic       br_en;
    br_func_e   br_func;
    logic       invalid;
  } ctrl_t;

  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } wb_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    ctrl_t                 ctrl;
  } dec_pkt_t;

endpackage

//--- src/id_regfile.sv
// general-purpose register file: two read ports, one write port, x0 tied low, write bypass
module id_regfile import id_pkg::*; #(
  parameter int NUM_REGS = 32,
  parameter int DATA_W   = XLEN,
  localparam int ADDR_W  = $clog2(NUM_REGS)
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [ADDR_W-1:0] i_raddr1,
  input  logic [ADDR_W-1:0] i_raddr2,
  input  wb_t               i_wb,
  output logic [DATA_W-1:0] o_rdata1,
  output logic [DATA_W-1:0] o_rdata2
);

  logic [DATA_W-1:0] regs [NUM_REGS];
  logic [ADDR_W-1:0] waddr;
  logic [DATA_W-1:0] wdata;
  logic              wr_en;

  assign waddr = ADDR_W'(i_wb.waddr);
  assign wdata = DATA_W'(i_wb.wdata);
  assign wr_en = i_wb.wen && (waddr != '0);  // x0 writes dropped

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr] <= wdata;
    end
  end

  // same-cycle write wins over the stored value
  assign o_rdata1 = (i_raddr1 == '0)                 ? '0    :
                    (wr_en && (i_raddr1 == waddr))   ? wdata : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0)                 ? '0    :
                    (wr_en && (i_raddr2 == waddr))   ? wdata : regs[i_raddr2];

endmodule

//--- src/id_top.sv
// decode top: fetch latch, control decoder, immediate generator, register file, issue register
module id_top import id_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  fetch_pkt_t i_fetch,
  input  logic       i_fetch_valid,
  output logic       o_fetch_ready,
  input  wb_t        i_wb,
  output dec_pkt_t   o_dec,
  output logic       o_dec_valid,
  input  logic       i_ex_ready
);

  localparam int NUM_REGS = 32;
  localparam int DATA_W   = XLEN;

  fetch_pkt_t        held;
  logic              held_valid;
  ctrl_t             ctrl;
  imm_fmt_e          imm_fmt;
  logic [XLEN-1:0]   imm;
  logic [DATA_W-1:0] rs1_data;
  logic [DATA_W-1:0] rs2_data;
  dec_pkt_t          issue_pkt;

  assign o_fetch_ready = i_ex_ready;  // both stages stall together

  id_fetch_latch u_fetch_latch (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_fetch      (i_fetch),
    .i_fetch_valid(i_fetch_valid),
    .i_advance    (i_ex_ready),
    .o_held       (held),
    .o_held_valid (held_valid)
  );

  id_ctrl_decoder u_ctrl_decoder (
    .i_inst   (held.inst),
    .o_ctrl   (ctrl),
    .o_imm_fmt(imm_fmt)
  );

  id_imm_gen u_imm_gen (
    .i_inst   (held.inst),
    .i_imm_fmt(imm_fmt),
    .o_imm    (imm)
  );

  id_regfile #(
    .NUM_REGS(NUM_REGS),
    .DATA_W  (DATA_W)
  ) u_regfile (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_raddr1(held.inst[19:15]),
    .i_raddr2(held.inst[24:20]),
    .i_wb    (i_wb),
    .o_rdata1(rs1_data),
    .o_rdata2(rs2_data)
  );

  assign issue_pkt.pc       = held.pc;
  assign issue_pkt.rd       = held.inst[11:7];
  assign issue_pkt.rs1_data = rs1_data;
  assign issue_pkt.rs2_data = rs2_data;
  assign issue_pkt.imm      = imm;
  assign issue_pkt.ctrl     = ctrl;

  id_issue_reg u_issue_reg (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_advance  (i_ex_ready),
    .i_valid    (held_valid),
    .i_pkt      (issue_pkt),
    .o_dec      (o_dec),
    .o_dec_valid(o_dec_valid)
  );

endmodule

//--- include/tb_vectors.svh
// decode vector table: instruction, expected control bundle, expected immediate, optional write-back
task automatic load_vectors();
  add_vec("lui",    32'h123452b7, op_ctrl(ALU_COPY_IMM, 1'b0, B_IMM, 1'b0),
          64'h0000_0000_1234_5000);
  add_vec("auipc",  32'hfffff317, op_ctrl(ALU_ADD, 1'b1, B_IMM, 1'b0), 64'hffff_ffff_ffff_f000);
  add_vec("jal",    32'hffdff0ef, jmp_ctrl(BR_JAL),  64'hffff_ffff_ffff_fffc);
  add_vec("jalr",   32'h008100e7, jmp_ctrl(BR_JALR), 64'h0000_0000_0000_0008);
  add_vec("beq",    32'h00208863, br_ctrl(BR_BEQ),   64'h0000_0000_0000_0010);
  add_vec("bne",    32'hfe209ce3, br_ctrl(BR_BNE),   64'hffff_ffff_ffff_fff8);
  add_vec("blt",    32'h0020c863, br_ctrl(BR_BLT),   64'h0000_0000_0000_0010);
  add_vec("bge",    32'h0020d863, br_ctrl(BR_BGE),   64'h0000_0000_0000_0010);
  add_vec("bltu",   32'h0020e863, br_ctrl(BR_BLTU),  64'h0000_0000_0000_0010);
  add_vec("bgeu",   32'h0020f863, br_ctrl(BR_BGEU),  64'h0000_0000_0000_0010);
  add_vec("lb",     32'hfff08383, ld_ctrl(MEM_SB_LB), 64'hffff_ffff_ffff_ffff);
  add_vec("lbu",    32'hfff0c383, ld_ctrl(MEM_LBU),   64'hffff_ffff_ffff_ffff);
  add_vec("lh",     32'hfff09383, ld_ctrl(MEM_SH_LH), 64'hffff_ffff_ffff_ffff);
  add_vec("lhu",    32'hfff0d383, ld_ctrl(MEM_LHU),   64'hffff_ffff_ffff_ffff);
  add_vec("lw",     32'hfff0a383, ld_ctrl(MEM_SW_LW), 64'hffff_ffff_ffff_ffff);
  add_vec("lwu",    32'hfff0e383, ld_ctrl(MEM_LWU),   64'hffff_ffff_ffff_ffff);
  add_vec("ld",     32'hfff0b383, ld_ctrl(MEM_SD_LD), 64'hffff_ffff_ffff_ffff);
  add_vec("sb",     32'hfe208fa3, st_ctrl(MEM_SB_LB), 64'hffff_ffff_ffff_ffff);
  add_vec("sw",     32'h0020ac23, st_ctrl(MEM_SW_LW), 64'h0000_0000_0000_0018);
  add_vec("sd",     32'h0020bc23, st_ctrl(MEM_SD_LD), 64'h0000_0000_0000_0018);
  add_vec("addi",   32'h80008413, op_ctrl(ALU_ADD, 1'b0, B_IMM, 1'b0), 64'hffff_ffff_ffff_f800);
  add_vec("srai",   32'h43f0d413, op_ctrl(ALU_SRA, 1'b0, B_IMM, 1'b0), 64'h0000_0000_0000_043f);
  add_vec("slli",   32'h02109413, op_ctrl(ALU_SLL, 1'b0, B_IMM, 1'b0), 64'h0000_0000_0000_0021);
  add_vec("sltiu",  32'h0010b413, op_ctrl(ALU_SLTU, 1'b0, B_IMM, 1'b0), 64'h0000_0000_0000_0001);
  add_vec("add",    32'h002084b3, op_ctrl(ALU_ADD, 1'b0, B_RS2, 1'b0), 64'h0);
  add_vec("sub",    32'h402084b3, op_ctrl(ALU_SUB, 1'b0, B_RS2, 1'b0), 64'h0);
  add_vec("xor",    32'h0020c4b3, op_ctrl(ALU_XOR, 1'b0, B_RS2, 1'b0), 64'h0);
  add_vec("sra",    32'h4020d4b3, op_ctrl(ALU_SRA, 1'b0, B_RS2, 1'b0), 64'h0);
  add_vec("and",    32'h0020f4b3, op_ctrl(ALU_AND, 1'b0, B_RS2, 1'b0), 64'h0);
  add_vec("addiw",  32'h0050851b, op_ctrl(ALU_ADD, 1'b0, B_IMM, 1'b1), 64'h0000_0000_0000_0005);
  add_vec("sraiw",  32'h4030d51b, op_ctrl(ALU_SRA, 1'b0, B_IMM, 1'b1), 64'h0000_0000_0000_0403);
  add_vec("addw",   32'h0020853b, op_ctrl(ALU_ADD, 1'b0, B_RS2, 1'b1), 64'h0);
  add_vec("subw",   32'h4020853b, op_ctrl(ALU_SUB, 1'b0, B_RS2, 1'b1), 64'h0);
  add_vec("sllw",   32'h0020953b, op_ctrl(ALU_SLL, 1'b0, B_RS2, 1'b1), 64'h0);
  add_vec("ones",   32'hffffffff, none_ctrl(1'b1), 64'h0);
  add_vec("mul",    32'h022084b3, none_ctrl(1'b1), 64'h0);  // M extension not kept
  add_vec("zero",   32'h00000000, none_ctrl(1'b0), 64'h0);
  // write lands while the add sits in the input stage
  add_wb("byp_x3",  32'h004185b3, op_ctrl(ALU_ADD, 1'b0, B_RS2, 1'b0), 64'h0,
         5'd3, 64'h3333_0000_0000_3333);
  add_wb("byp_x4",  32'h004185b3, op_ctrl(ALU_ADD, 1'b0, B_RS2, 1'b0), 64'h0,
         5'd4, 64'h4444_0000_0000_4444);
  add_vec("rd_x0",  32'h00200633, op_ctrl(ALU_ADD, 1'b0, B_RS2, 1'b0), 64'h0);
endtask

//--- test/tb_id_top.sv
// testbench for id_top with vector table, random back-pressure, scoreboard, register model, watchdog
module tb_id_top import id_pkg::*; ();

  typedef struct {
    string                 name;
    logic [INST_W-1:0]     inst;
    logic [XLEN-1:0]       pc;
    ctrl_t                 ctrl;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] wb_reg;
    logic [XLEN-1:0]       wb_val;
  } vec_t;

  logic       i_clk = 1'b0;
  logic       i_rst_n;
  fetch_pkt_t i_fetch;
  logic       i_fetch_valid;
  logic       o_fetch_ready;
  wb_t        i_wb;
  dec_pkt_t   o_dec;
  logic       o_dec_valid;
  logic       i_ex_ready = 1'b1;

  integer          seed = 32'h8234_79a4;
  vec_t            vecs[$];
  int              exp_idx[$];
  logic [XLEN-1:0] exp_rs1[$];
  logic [XLEN-1:0] exp_rs2[$];
  logic [XLEN-1:0] model[32];  // expected register contents
  int              errors = 0;
  logic            rand_en = 1'b0;
  logic            loaded = 1'b0;
  logic            stalled = 1'b0;
  dec_pkt_t        prev_dec;
  logic            prev_valid;

  always #4 i_clk = ~i_clk;

  id_top i_id_top (.*);

  function automatic ctrl_t none_ctrl(input logic inv);
    ctrl_t c;
    c         = '0;
    c.alu_op  = ALU_INVALID;
    c.b_src   = B_RS2;
    c.mem_op  = MEM_NONE;
    c.br_func = BR_JAL;
    c.invalid = inv;
    return c;
  endfunction

  function automatic ctrl_t op_ctrl(input alu_op_e op, input logic a_pc,
                                    input alu_b_src_e b, input logic word);
    ctrl_t c;
    c          = none_ctrl(1'b0);
    c.alu_op   = op;
    c.a_src_pc = a_pc;
    c.b_src    = b;
    c.word_cut = word;
    c.reg_wr   = 1'b1;
    return c;
  endfunction

  function automatic ctrl_t ld_ctrl(input mem_op_e m);
    ctrl_t c;
    c            = op_ctrl(ALU_ADD, 1'b0, B_IMM, 1'b0);
    c.mem_to_reg = 1'b1;
    c.mem_re     = 1'b1;
    c.mem_op     = m;
    return c;
  endfunction

  function automatic ctrl_t st_ctrl(input mem_op_e m);
    ctrl_t c;
    c        = none_ctrl(1'b0);
    c.alu_op = ALU_ADD;
    c.b_src  = B_IMM;
    c.mem_wr = 1'b1;
    c.mem_op = m;
    return c;
  endfunction

  function automatic ctrl_t br_ctrl(input br_func_e f);
    ctrl_t c;
    c         = none_ctrl(1'b0);
    c.alu_op  = ALU_SUB;
    c.br_en   = 1'b1;
    c.br_func = f;
    return c;
  endfunction

  function automatic ctrl_t jmp_ctrl(input br_func_e f);
    ctrl_t c;
    c         = op_ctrl(ALU_ADD, 1'b1, B_CONST4, 1'b0);
    c.br_en   = 1'b1;
    c.br_func = f;
    return c;
  endfunction

  task automatic add_wb(input string name, input logic [INST_W-1:0] inst, input ctrl_t c,
                        input logic [XLEN-1:0] imm, input logic [REG_ADDR_W-1:0] r,
                        input logic [XLEN-1:0] val);
    vec_t v;
    v.name   = name;
    v.inst   = inst;
    v.pc     = 64'h0000_0000_8000_0000 + 64'(vecs.size() * 4);
    v.ctrl   = c;
    v.imm    = imm;
    v.wb_reg = r;
    v.wb_val = val;
    vecs.push_back(v);
  endtask

  task automatic add_vec(input string name, input logic [INST_W-1:0] inst, input ctrl_t c,
                         input logic [XLEN-1:0] imm);
    add_wb(name, inst, c, imm, '0, '0);
  endtask

  `include "tb_vectors.svh"

  task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s ctrl: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp,
                          input logic [REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s rd: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic write_reg(input logic [REG_ADDR_W-1:0] r, input logic [XLEN-1:0] val);
    wb_t w;
    w.wen   = 1'b1;
    w.waddr = r;
    w.wdata = val;
    @(posedge i_clk);
    i_wb <= w;
    if (r != '0) model[r] = val;  // x0 stays zero
  endtask

  // execute side back-pressure
  always @(posedge i_clk) begin
    i_ex_ready <= rand_en ? (($random(seed) & 32'd3) != 32'd0) : 1'b1;
  end

  // stall stability and scoreboard
  always @(posedge i_clk) begin
    int   idx;
    vec_t v;
    if (i_rst_n) begin
      if (o_fetch_ready !== i_ex_ready) begin
        errors++;
        $display("o_fetch_ready did not follow i_ex_ready");
      end
      if (stalled && (o_dec !== prev_dec || o_dec_valid !== prev_valid)) begin
        errors++;
        $display("output packet changed while i_ex_ready was low");
      end
      if (o_dec_valid && i_ex_ready) begin
        if (exp_idx.size() == 0) begin
          errors++;
          $display("valid packet issued with no accepted instruction pending");
        end else begin
          idx = exp_idx.pop_front();
          v   = vecs[idx];
          check_ctrl(v.name, v.ctrl, o_dec.ctrl);
          check_data({v.name, " imm"}, v.imm, o_dec.imm);
          check_data({v.name, " pc"}, v.pc, o_dec.pc);
          check_data({v.name, " rs1"}, exp_rs1.pop_front(), o_dec.rs1_data);
          check_data({v.name, " rs2"}, exp_rs2.pop_front(), o_dec.rs2_data);
          check_rd(v.name, v.inst[11:7], o_dec.rd);
        end
      end
      stalled    = !i_ex_ready;
      prev_dec   = o_dec;
      prev_valid = o_dec_valid;
    end
  end

  initial begin
    int limit;
    wait (loaded);
    limit = (vecs.size() * 20 + 50) * 8;
    #(limit);
    $display("timeout: the pipeline did not deliver every instruction in time");
    $display("%0d errors", errors + 1);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    fetch_pkt_t f;
    wb_t        w;
    vec_t       v;
    i_rst_n       = 1'b0;
    i_fetch       = '0;
    i_fetch_valid = 1'b0;
    i_wb          = '0;
    for (int r = 0; r < 32; r++) model[r] = '0;
    load_vectors();
    loaded = 1'b1;

    repeat (3) begin
      @(negedge i_clk);
      if (o_dec_valid !== 1'b0) begin
        errors++;
        $display("o_dec_valid was not low during reset");
      end
    end
    @(posedge i_clk);
    i_rst_n <= 1'b1;

    write_reg(5'd1, 64'h0123_4567_89ab_cdef);
    write_reg(5'd2, 64'hffff_ffff_ffff_fff0);
    write_reg(5'd3, 64'h0000_0000_0000_0033);
    write_reg(5'd4, 64'h0000_0000_0000_0044);
    write_reg(5'd0, 64'hdead_beef_dead_beef);
    @(posedge i_clk);
    i_wb    <= '0;
    rand_en <= 1'b1;

    for (int i = 0; i < vecs.size(); i++) begin
      v      = vecs[i];
      f.pc   = v.pc;
      f.inst = v.inst;
      i_fetch       <= f;
      i_fetch_valid <= 1'b1;
      do begin
        @(posedge i_clk);
        i_wb <= '0;
      end while (!o_fetch_ready);
      if (v.wb_reg != '0) begin
        w.wen   = 1'b1;
        w.waddr = v.wb_reg;
        w.wdata = v.wb_val;
        i_wb <= w;
        model[v.wb_reg] = v.wb_val;
      end
      exp_idx.push_back(i);
      exp_rs1.push_back(model[v.inst[19:15]]);
      exp_rs2.push_back(model[v.inst[24:20]]);
    end
    i_fetch_valid <= 1'b0;

    while (exp_idx.size() != 0) @(posedge i_clk);
    repeat (2) @(posedge i_clk);
    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
